// File: src/decodePkg.sv
`default_nettype none

package decodePkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opcLoad    = 5'b00000,
        opcOpImm   = 5'b00100,
        opcAuipc   = 5'b00101,
        opcOpImm32 = 5'b00110,
        opcStore   = 5'b01000,
        opcOp      = 5'b01100,
        opcLui     = 5'b01101,
        opcOp32    = 5'b01110,
        opcBranch  = 5'b11000,
        opcJalr    = 5'b11001,
        opcJal     = 5'b11011,
        opcSystem  = 5'b11100
    } opcodeE;

    // fmtR means no immediate
    typedef enum logic [2:0] {
        fmtI, fmtS, fmtB, fmtU, fmtJ, fmtR
    } immFmtE;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd,
        aluMul, aluMulh, aluMulhsu, aluMulhu,
        aluDiv, aluDivu, aluRem, aluRemu,
        aluPassB                               // lui, csr
    } aluOpE;

    typedef enum logic [3:0] {
        brNone, brJal, brJalr,
        brBeq, brBne, brBlt, brBge, brBltu, brBgeu
    } branchE;

    typedef enum logic [1:0] {
        bSrcRs2,
        bSrcFour,    // pc+4 link value
        bSrcImm,
        bSrcCsr
    } aluBSrcE;

endpackage

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic [31:0]        instr,
    output decodePkg::aluOpE   aluOp,
    output logic               aluASrcPc,
    output decodePkg::aluBSrcE aluBSrc,
    output logic               word,
    output decodePkg::branchE  branch,
    output logic               memRd,
    output logic               memWr,
    output logic [2:0]         memOp,
    output logic               regWr,
    output logic               usesRs1,
    output logic               usesRs2,
    output decodePkg::immFmtE  immFmt,
    output logic               isSystem,
    output logic               illegal
);
    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       badOp;    // encoding error within a known opcode

    function automatic decodePkg::aluOpE baseAluOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  baseAluOp = alt ? decodePkg::aluSub : decodePkg::aluAdd;
            3'b001:  baseAluOp = decodePkg::aluSll;
            3'b010:  baseAluOp = decodePkg::aluSlt;
            3'b011:  baseAluOp = decodePkg::aluSltu;
            3'b100:  baseAluOp = decodePkg::aluXor;
            3'b101:  baseAluOp = alt ? decodePkg::aluSra : decodePkg::aluSrl;
            3'b110:  baseAluOp = decodePkg::aluOr;
            default: baseAluOp = decodePkg::aluAnd;
        endcase
    endfunction

    function automatic decodePkg::aluOpE mulAluOp(input logic [2:0] f3);
        case (f3)
            3'b000:  mulAluOp = decodePkg::aluMul;
            3'b001:  mulAluOp = decodePkg::aluMulh;
            3'b010:  mulAluOp = decodePkg::aluMulhsu;
            3'b011:  mulAluOp = decodePkg::aluMulhu;
            3'b100:  mulAluOp = decodePkg::aluDiv;
            3'b101:  mulAluOp = decodePkg::aluDivu;
            3'b110:  mulAluOp = decodePkg::aluRem;
            default: mulAluOp = decodePkg::aluRemu;
        endcase
    endfunction

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        aluOp     = decodePkg::aluAdd;
        aluASrcPc = 1'b0;
        aluBSrc   = decodePkg::bSrcImm;
        branch    = decodePkg::brNone;
        immFmt    = decodePkg::fmtR;
        badOp     = 1'b0;
        case (opcode)
            decodePkg::opcLoad: begin
                immFmt = decodePkg::fmtI;
                badOp  = (funct3 == 3'b111);
            end
            decodePkg::opcStore: begin
                immFmt = decodePkg::fmtS;
                badOp  = funct3[2];
            end
            decodePkg::opcOpImm: begin
                immFmt = decodePkg::fmtI;
                aluOp  = baseAluOp(funct3, funct7[5] && funct3 == 3'b101);
                badOp  = (funct3 == 3'b001 && instr[31:26] != 6'b000000) ||
                         (funct3 == 3'b101 && instr[31:26] != 6'b000000 &&
                          instr[31:26] != 6'b010000);    // 6-bit shamt
            end
            decodePkg::opcOpImm32: begin
                immFmt = decodePkg::fmtI;
                aluOp  = baseAluOp(funct3, funct7[5] && funct3 == 3'b101);
                badOp  = (funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101) ||
                         (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                         (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000);
            end
            decodePkg::opcOp, decodePkg::opcOp32: begin
                aluBSrc = decodePkg::bSrcRs2;
                aluOp   = (funct7 == 7'b0000001) ? mulAluOp(funct3) : baseAluOp(funct3, funct7[5]);
                case (funct7)
                    7'b0000000: badOp = (opcode == decodePkg::opcOp32) &&
                                        !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101);
                    7'b0100000: badOp = !(funct3 == 3'b000 || funct3 == 3'b101);
                    7'b0000001: badOp = (opcode == decodePkg::opcOp32) &&
                                        (funct3 == 3'b001 || funct3 == 3'b010 || funct3 == 3'b011);
                    default:    badOp = 1'b1;
                endcase
            end
            decodePkg::opcLui: begin
                immFmt = decodePkg::fmtU;
                aluOp  = decodePkg::aluPassB;
            end
            decodePkg::opcAuipc: begin
                immFmt    = decodePkg::fmtU;
                aluASrcPc = 1'b1;
            end
            decodePkg::opcJal: begin
                immFmt    = decodePkg::fmtJ;
                aluASrcPc = 1'b1;
                aluBSrc   = decodePkg::bSrcFour;
                branch    = decodePkg::brJal;
            end
            decodePkg::opcJalr: begin
                immFmt    = decodePkg::fmtI;
                aluASrcPc = 1'b1;
                aluBSrc   = decodePkg::bSrcFour;
                branch    = decodePkg::brJalr;
                badOp     = (funct3 != 3'b000);
            end
            decodePkg::opcBranch: begin
                immFmt  = decodePkg::fmtB;
                aluBSrc = decodePkg::bSrcRs2;
                case (funct3)
                    3'b000: begin aluOp = decodePkg::aluSub;  branch = decodePkg::brBeq;  end
                    3'b001: begin aluOp = decodePkg::aluSub;  branch = decodePkg::brBne;  end
                    3'b100: begin aluOp = decodePkg::aluSlt;  branch = decodePkg::brBlt;  end
                    3'b101: begin aluOp = decodePkg::aluSlt;  branch = decodePkg::brBge;  end
                    3'b110: begin aluOp = decodePkg::aluSltu; branch = decodePkg::brBltu; end
                    3'b111: begin aluOp = decodePkg::aluSltu; branch = decodePkg::brBgeu; end
                    default: badOp = 1'b1;
                endcase
            end
            decodePkg::opcSystem: begin
                immFmt  = decodePkg::fmtI;
                aluBSrc = decodePkg::bSrcCsr;
                aluOp   = decodePkg::aluPassB;
                badOp   = (funct3 == 3'b100);
            end
            default: badOp = 1'b1;
        endcase
    end

    assign memRd    = (opcode == decodePkg::opcLoad);
    assign memWr    = (opcode == decodePkg::opcStore);
    assign memOp    = funct3;
    assign regWr    = !(opcode == decodePkg::opcBranch || opcode == decodePkg::opcStore);
    assign word     = (opcode == decodePkg::opcOpImm32 || opcode == decodePkg::opcOp32);
    assign isSystem = (opcode == decodePkg::opcSystem);
    // csr immediate forms carry zimm in the rs1 field
    assign usesRs1  = (immFmt inside {decodePkg::fmtI, decodePkg::fmtS, decodePkg::fmtB,
                                      decodePkg::fmtR}) && !(isSystem && funct3[2]);
    assign usesRs2  = immFmt inside {decodePkg::fmtS, decodePkg::fmtB, decodePkg::fmtR};
    assign illegal  = badOp || (instr[1:0] != 2'b11);

endmodule

`default_nettype wire

// File: src/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  logic [31:0]       instr,
    input  decodePkg::immFmtE fmt,
    output logic [31:0]       imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            decodePkg::fmtI: imm = {{20{sign}}, instr[31:20]};
            decodePkg::fmtS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            decodePkg::fmtB: imm = {{19{sign}}, sign, instr[7], instr[30:25],
                                    instr[11:8], 1'b0};
            decodePkg::fmtU: imm = {instr[31:12], 12'b0};
            decodePkg::fmtJ: imm = {{11{sign}}, sign, instr[19:12], instr[20],
                                    instr[30:21], 1'b0};
            default:         imm = 32'b0;    // no immediate
        endcase
    end

endmodule

`default_nettype wire

// File: src/regScoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module regScoreboard #(
    parameter int NUM_REGS = 32
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       setEn,
    input  logic [4:0] setRd,
    input  logic       wbValid,
    input  logic [4:0] wbRd,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    output logic       rs1Pending,
    output logic       rs2Pending
);
    logic [NUM_REGS-1:0] pending;    // one write in flight per bit

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pending <= '0;
        end else begin
            // x0 is skipped so its bit stays clear
            for (int r = 1; r < NUM_REGS; r++) begin
                if (setEn && setRd == 5'(r)) begin
                    pending[r] <= 1'b1;    // newer issue beats writeback
                end else if (wbValid && wbRd == 5'(r)) begin
                    pending[r] <= 1'b0;
                end
            end
        end
    end

    assign rs1Pending = pending[rs1];
    assign rs2Pending = pending[rs2];

endmodule

`default_nettype wire

// File: src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
    parameter int XLEN = 64
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  logic [31:0]        inInstr,
    input  logic [XLEN-1:0]    inPc,
    input  logic               inFault,
    output logic               inReady,
    output logic               outValid,
    output logic [XLEN-1:0]    outPc,
    output logic [31:0]        outImm,
    output logic [4:0]         outRd,
    output logic [4:0]         outRs1,
    output logic [4:0]         outRs2,
    output decodePkg::aluOpE   outAluOp,
    output logic               outAluASrcPc,
    output decodePkg::aluBSrcE outAluBSrc,
    output logic               outWord,
    output decodePkg::branchE  outBranch,
    output logic               outMemRd,
    output logic               outMemWr,
    output logic [2:0]         outMemOp,
    output logic               outRegWr,
    output logic [11:0]        outCsrAddr,
    output logic               outEcall,
    output logic               outEbreak,
    output logic               outMret,
    output logic               outIllegal,
    input  logic               exReady,
    input  logic               flush,
    input  logic               rs1Pending,
    input  logic               rs2Pending,
    output logic               setEn,
    output logic [4:0]         setRd,
    output logic               rsBlock
);
    logic              heldValid;
    logic [31:0]       heldInstr;
    logic [XLEN-1:0]   heldPc;
    logic              heldFault;
    decodePkg::immFmtE immFmt;
    logic              decMemRd;
    logic              decMemWr;
    logic              decRegWr;
    logic              usesRs1;
    logic              usesRs2;
    logic              isSystem;
    logic              decIllegal;
    logic              sysMatch;    // one of the three exact system words
    logic              issue;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
        end else if (inReady) begin
            heldValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inReady) begin
            heldInstr <= inInstr;
            heldPc    <= inPc;
            heldFault <= inFault;
        end
    end

    instrDecoder decoder (
        .instr(heldInstr), .aluOp(outAluOp), .aluASrcPc(outAluASrcPc),
        .aluBSrc(outAluBSrc), .word(outWord), .branch(outBranch),
        .memRd(decMemRd), .memWr(decMemWr), .memOp(outMemOp), .regWr(decRegWr),
        .usesRs1(usesRs1), .usesRs2(usesRs2), .immFmt(immFmt),
        .isSystem(isSystem), .illegal(decIllegal)
    );

    immGen immUnit (
        .instr(heldInstr),
        .fmt(immFmt),
        .imm(outImm)
    );

    assign rsBlock  = heldValid && !flush &&
                      ((usesRs1 && rs1Pending) || (usesRs2 && rs2Pending));
    assign outValid = heldValid && !flush && !rsBlock;
    assign issue    = outValid && exReady;
    assign inReady  = !heldValid || issue || flush;

    assign outEcall   = !heldFault && heldInstr == 32'h0000_0073;
    assign outEbreak  = !heldFault && heldInstr == 32'h0010_0073;
    assign outMret    = !heldFault && heldInstr == 32'h3020_0073;
    assign sysMatch   = outEcall || outEbreak || outMret;
    assign outIllegal = decIllegal || heldFault ||
                        (isSystem && heldInstr[14:12] == 3'b000 && !sysMatch);

    // illegal words must not touch state
    assign outRegWr = decRegWr && !outIllegal;
    assign outMemWr = decMemWr && !outIllegal;
    assign outMemRd = decMemRd && !outIllegal;

    assign outPc      = heldPc;
    assign outRd      = heldInstr[11:7];
    assign outRs1     = heldInstr[19:15];
    assign outRs2     = heldInstr[24:20];
    assign outCsrAddr = heldInstr[31:20];

    assign setEn = issue && outRegWr && outRd != 5'd0;
    assign setRd = outRd;

endmodule

`default_nettype wire

// File: src/decodeTop.sv
`timescale 1ns/1ps
`default_nettype none

module decodeTop #(
    parameter int XLEN     = 64,
    parameter int NUM_REGS = 32
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  logic [31:0]        inInstr,
    input  logic [XLEN-1:0]    inPc,
    input  logic               inFault,
    output logic               inReady,
    output logic               outValid,
    output logic [XLEN-1:0]    outPc,
    output logic [31:0]        outImm,
    output logic [4:0]         outRd,
    output logic [4:0]         outRs1,
    output logic [4:0]         outRs2,
    output decodePkg::aluOpE   outAluOp,
    output logic               outAluASrcPc,
    output decodePkg::aluBSrcE outAluBSrc,
    output logic               outWord,
    output decodePkg::branchE  outBranch,
    output logic               outMemRd,
    output logic               outMemWr,
    output logic [2:0]         outMemOp,
    output logic               outRegWr,
    output logic [11:0]        outCsrAddr,
    output logic               outEcall,
    output logic               outEbreak,
    output logic               outMret,
    output logic               outIllegal,
    input  logic               exReady,
    input  logic               wbValid,
    input  logic [4:0]         wbRd,
    input  logic               flush,
    output logic               rsBlock
);
    logic       rs1Pending;
    logic       rs2Pending;
    logic       setEn;
    logic [4:0] setRd;    // destination marked on issue

    decodeStage #(
        .XLEN(XLEN)
    ) stage (
        .clk(clk), .arstN(arstN),
        .inValid(inValid), .inInstr(inInstr), .inPc(inPc),
        .inFault(inFault), .inReady(inReady),
        .outValid(outValid), .outPc(outPc), .outImm(outImm),
        .outRd(outRd), .outRs1(outRs1), .outRs2(outRs2),
        .outAluOp(outAluOp), .outAluASrcPc(outAluASrcPc), .outAluBSrc(outAluBSrc),
        .outWord(outWord), .outBranch(outBranch),
        .outMemRd(outMemRd), .outMemWr(outMemWr), .outMemOp(outMemOp),
        .outRegWr(outRegWr), .outCsrAddr(outCsrAddr),
        .outEcall(outEcall), .outEbreak(outEbreak), .outMret(outMret),
        .outIllegal(outIllegal), .exReady(exReady), .flush(flush),
        .rs1Pending(rs1Pending), .rs2Pending(rs2Pending),
        .setEn(setEn), .setRd(setRd), .rsBlock(rsBlock)
    );

    regScoreboard #(
        .NUM_REGS(NUM_REGS)
    ) scoreboard (
        .clk(clk), .arstN(arstN),
        .setEn(setEn), .setRd(setRd),
        .wbValid(wbValid), .wbRd(wbRd),
        .rs1(outRs1), .rs2(outRs2),
        .rs1Pending(rs1Pending), .rs2Pending(rs2Pending)
    );

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);
    initial clk = 1'b0;
    always #5 clk = ~clk;    // 10 ns period
endmodule

`default_nettype wire

// File: testbench/tbRefModel.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// sign-extended immediate chosen by major opcode
function automatic logic [31:0] expectedImm(input logic [31:0] w);
    case (w[6:2])
        5'b00000, 5'b00100, 5'b00110, 5'b11001, 5'b11100: return 32'($signed(w[31:20]));
        5'b01000: return 32'($signed({w[31:25], w[11:7]}));
        5'b11000: return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        5'b00101, 5'b01101: return {w[31:12], 12'h000};
        5'b11011: return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        default: return 32'h0;    // register format
    endcase
endfunction

function automatic logic isIllegal(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       bad;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:2])
        5'b00000: bad = (f3 == 3'd7);
        5'b01000: bad = (f3 > 3'd3);
        5'b00100: bad = (f3 == 3'd1 && w[31:26] != 6'h00) ||
                        (f3 == 3'd5 && !(w[31:26] inside {6'h00, 6'h10}));
        5'b00110: bad = !(f3 inside {3'd0, 3'd1, 3'd5}) ||
                        (f3 != 3'd0 && !(f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)));
        5'b01100: bad = !(f7 inside {7'h00, 7'h01} || (f7 == 7'h20 && f3 inside {3'd0, 3'd5}));
        5'b01110: bad = !((f7 == 7'h00 && f3 inside {3'd0, 3'd1, 3'd5}) ||
                          (f7 == 7'h20 && f3 inside {3'd0, 3'd5}) ||
                          (f7 == 7'h01 && !(f3 inside {3'd1, 3'd2, 3'd3})));
        5'b11000: bad = (f3 inside {3'd2, 3'd3});
        5'b11001: bad = (f3 != 3'd0);
        5'b11100: bad = (f3 == 3'd4) ||
                        (f3 == 3'd0 && !(w inside {32'h0000_0073, 32'h0010_0073,
                                                   32'h3020_0073}));
        5'b00101, 5'b01101, 5'b11011: bad = 1'b0;
        default: bad = 1'b1;
    endcase
    return bad || w[1:0] != 2'b11;
endfunction

// no rs1 for lui, auipc, jal or csr immediates
function automatic logic readsRs1(input logic [31:0] w);
    return !(w[6:2] inside {5'b01101, 5'b00101, 5'b11011}) &&
           !(w[6:2] == 5'b11100 && w[14]);
endfunction

// unknown opcodes count as register format
function automatic logic readsRs2(input logic [31:0] w);
    return !(w[6:2] inside {5'b00000, 5'b00100, 5'b00110, 5'b11001, 5'b11100,
                            5'b01101, 5'b00101, 5'b11011});
endfunction

function automatic logic writesRd(input logic [31:0] w);
    return !(w[6:2] inside {5'b11000, 5'b01000});
endfunction

// control transfer kind of a legal word
function automatic decodePkg::branchE branchOf(input logic [31:0] w);
    if (w[6:2] == 5'b11011) return decodePkg::brJal;
    if (w[6:2] == 5'b11001) return decodePkg::brJalr;
    if (w[6:2] != 5'b11000) return decodePkg::brNone;
    case (w[14:12])
        3'd0: return decodePkg::brBeq;
        3'd1: return decodePkg::brBne;
        3'd4: return decodePkg::brBlt;
        3'd5: return decodePkg::brBge;
        3'd6: return decodePkg::brBltu;
        3'd7: return decodePkg::brBgeu;
        default: return decodePkg::brNone;
    endcase
endfunction

`endif

// File: testbench/decodeTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeTb;
    localparam int XLEN      = 64;
    localparam int NUM_INSTR = 400;
    localparam logic [4:0] OPCODE_TABLE [12] = '{
        5'b00000, 5'b00100, 5'b00101, 5'b00110, 5'b01000, 5'b01100,
        5'b01101, 5'b01110, 5'b11000, 5'b11001, 5'b11011, 5'b11100
    };

    logic clk, arstN;
    logic inValid, inFault, inReady, exReady, wbValid, flush, rsBlock;
    logic [31:0] inInstr, outImm;
    logic [XLEN-1:0] inPc, outPc;
    logic [4:0] wbRd, outRd, outRs1, outRs2;
    logic [2:0] outMemOp;
    logic [11:0] outCsrAddr;
    logic outValid, outAluASrcPc, outWord, outMemRd, outMemWr, outRegWr;
    logic outEcall, outEbreak, outMret, outIllegal;
    decodePkg::aluOpE outAluOp;
    decodePkg::aluBSrcE outAluBSrc;
    decodePkg::branchE outBranch;

    logic heldV, heldF, lastTaken;    // model of the held slot
    logic [31:0] heldW, pendM, expImm;
    logic [XLEN-1:0] heldP;
    logic expIll, expBlock, expOutValid, expIssue, expInReady, expRegWr;
    int accepted, issued, flushed, errCount;
    logic [31:0] lfsrState = 32'hc619_e694;

    `include "tbRefModel.svh"

    tbClock clkGen (.clk(clk));

    decodeTop #(.XLEN(XLEN), .NUM_REGS(32)) uut (.*);

    // taps 32, 22, 2, 1; one step per bit
    function automatic logic [31:0] rnd(input int nBits);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < nBits; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] genInstr();
        logic [2:0] kind;
        logic [6:0] f7;
        kind = 3'(rnd(3));
        if (kind == 3'd0) begin
            return rnd(32) & 32'hfe73_f3ff;    // rd, rs1 and rs2 within x0..x7
        end else if (kind == 3'd1) begin
            case (2'(rnd(2)))
                2'd0: return 32'h0000_0073;
                2'd1: return 32'h0010_0073;
                2'd2: return 32'h3020_0073;
                default: return {12'(rnd(12)), 5'(rnd(5)), 3'b000, 5'(rnd(5)), 7'h73};
            endcase
        end
        case (2'(rnd(2)))
            2'd0: f7 = 7'h00;
            2'd1: f7 = 7'h20;
            2'd2: f7 = 7'h01;
            default: f7 = 7'(rnd(7));
        endcase
        // registers kept to x0..x7 so hazards are frequent
        return {f7, 2'b00, 3'(rnd(3)), 2'b00, 3'(rnd(3)), 3'(rnd(3)), 2'b00, 3'(rnd(3)),
                OPCODE_TABLE[rnd(4) % 12], 2'b11};
    endfunction

    task automatic randomizeSideInputs();
        exReady = (rnd(2) != 0);
        flush   = (rnd(4) == 0);
        wbValid = rnd(1) != 0;
        wbRd    = {2'b00, 3'(rnd(3))};
    endtask

    task automatic reportMismatch(input string msg);
        errCount++;
        $display("Fail %0t ns: %s", $time, msg);
    endtask

    always_comb begin
        expIll      = isIllegal(heldW) || heldF;
        expImm      = expectedImm(heldW);
        expRegWr    = writesRd(heldW) && !expIll;
        expBlock    = heldV && !flush &&
                      ((readsRs1(heldW) && pendM[heldW[19:15]]) ||
                       (readsRs2(heldW) && pendM[heldW[24:20]]));
        expOutValid = heldV && !flush && !expBlock;
        expIssue    = expOutValid && exReady;
        expInReady  = !heldV || expIssue || flush;
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldV     <= 1'b0;
            heldW     <= '0;
            heldP     <= '0;
            heldF     <= 1'b0;
            pendM     <= '0;
            lastTaken <= 1'b0;
            accepted  <= 0;
            issued    <= 0;
            flushed   <= 0;
        end else begin
            for (int r = 1; r < 32; r++) begin
                if (expIssue && expRegWr && heldW[11:7] == 5'(r)) begin
                    pendM[r] <= 1'b1;    // issue wins over writeback
                end else if (wbValid && wbRd == 5'(r)) begin
                    pendM[r] <= 1'b0;
                end
            end
            if (expIssue) issued <= issued + 1;
            if (flush && heldV) flushed <= flushed + 1;
            lastTaken <= inValid && expInReady;
            if (expInReady) begin
                heldV <= inValid;
                heldW <= inInstr;
                heldP <= inPc;
                heldF <= inFault;
                if (inValid) accepted <= accepted + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        outValid == expOutValid && rsBlock == expBlock)
        else reportMismatch("outValid or rsBlock differs from the hazard model");
    assert property (@(posedge clk) disable iff (!arstN) inReady == expInReady)
        else reportMismatch("inReady differs from the model");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> outPc == heldP && outImm == expImm)
        else reportMismatch("outPc or outImm wrong on issue");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> outIllegal == expIll && outRegWr == expRegWr)
        else reportMismatch("outIllegal or outRegWr wrong");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && outIllegal |-> !outRegWr && !outMemWr)
        else reportMismatch("illegal instruction writes state");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> outRd == heldW[11:7] && outRs1 == heldW[19:15] &&
            outRs2 == heldW[24:20] && outCsrAddr == heldW[31:20] &&
            outMemOp == heldW[14:12])
        else reportMismatch("register fields, csr address or memOp wrong");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && !expIll |-> outMemRd == (heldW[6:2] == 5'b00000) &&
            outMemWr == (heldW[6:2] == 5'b01000) &&
            outWord == (heldW[6:2] inside {5'b00110, 5'b01110}) &&
            outAluASrcPc == (heldW[6:2] inside {5'b00101, 5'b11011, 5'b11001}) &&
            outBranch == branchOf(heldW))
        else reportMismatch("memory, word, pc operand or branch control wrong");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && !heldF |-> outEcall == (heldW == 32'h0000_0073) &&
            outEbreak == (heldW == 32'h0010_0073) && outMret == (heldW == 32'h3020_0073))
        else reportMismatch("system flag wrong");
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && !exReady |=> $stable({outPc, outImm, outRd, outRs1, outRs2, outAluOp,
            outAluASrcPc, outAluBSrc, outWord, outBranch, outMemRd, outMemWr, outMemOp,
            outRegWr, outCsrAddr, outEcall, outEbreak, outMret, outIllegal}))
        else reportMismatch("outputs changed under back-pressure");
    assert property (@(posedge clk) disable iff (!arstN) flush |-> !outValid)
        else reportMismatch("outValid high during flush");

    initial begin
        arstN   = 1'b0;
        inValid = 1'b0;
        inInstr = '0;
        inPc    = '0;
        inFault = 1'b0;
        exReady = 1'b0;
        wbValid = 1'b0;
        wbRd    = '0;
        flush   = 1'b0;
        repeat (16) @(posedge clk);
        #1 arstN = 1'b1;
        while (accepted < NUM_INSTR) begin
            if (lastTaken || !inValid) begin    // hold an offer until taken
                inValid = (rnd(2) != 0);
                inInstr = genInstr();
                inFault = (rnd(4) == 0);
                inPc    = 64'h8000_0000 + 64'(accepted) * 4;
            end
            randomizeSideInputs();
            @(posedge clk);
            #1;
        end
        inValid = 1'b0;
        while (heldV) begin
            randomizeSideInputs();
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        $display("accepted %0d, issued %0d, flushed %0d, errors %0d",
                 accepted, issued, flushed, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_INSTR * 40) @(posedge clk);
        $display("Timeout: instructions did not drain within %0d cycles", NUM_INSTR * 40);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+testbench
src/decodePkg.sv
src/instrDecoder.sv
src/immGen.sv
src/regScoreboard.sv
src/decodeStage.sv
src/decodeTop.sv
testbench/tbClock.sv
testbench/decodeTb.sv
